// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_board, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_board -Mdir obj_dir
	./obj_dir/Vtb_board | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: bench/board_tests.txt
# name  key_mask(hex: 1 run/stop, 2 clear, 4 lap)  steps  digits(hex, ffff = moving)  led(hex)
# a vector lasts steps+3 periods, steps+5 with lap hold, and a run counts all of them
reset_zero      0  0  0000  0
start_a         1  2  ffff  1
stop_a          1  0  0005  0
start_b         1  1  ffff  1
stop_b          1  0  0009  0
start_c         1  0  ffff  1
stop_carry_ten  1  0  0012  0
clear_stopped   2  0  0000  0
start_d         1  2  ffff  1
clear_running   2  1  ffff  1
lap_hold        4  0  ffff  3
lap_release     4  1  ffff  1
stop_d          1  0  0018  0
start_e         1  78 ffff  1
stop_e          1  0  0099  0
start_f         1  0  ffff  1
stop_carry_100  1  0  0102  0
clear_end       2  0  0000  0
idle_end        0  0  0000  0

// File: bench/display_checker.sv
`timescale 1ns/1ps
`default_nettype none

module display_checker
    import stopwatch_pkg::*;
#(
    parameter int step_period = 20,
    parameter int scan_period = 2
)
(
    input wire logic                clk,
    input wire logic [n_digits-1:0] digit,
    input wire seg_t                hgfedcba,
    input wire logic [3:0]          led
);

    localparam int scan_len = n_digits * scan_period;  // cycles in one full scan.

    int value_errors = 0;
    int other_errors = 0;

    // standard seven segment patterns in abcdefgh order with the point off.
    function automatic logic [3:0] seg_to_digit(input seg_t abcdefgh);
        case (abcdefgh)
            8'b1111_1100: return 4'd0;
            8'b0110_0000: return 4'd1;
            8'b1101_1010: return 4'd2;
            8'b1111_0010: return 4'd3;
            8'b0110_0110: return 4'd4;
            8'b1011_0110: return 4'd5;
            8'b1011_1110: return 4'd6;
            8'b1110_0000: return 4'd7;
            8'b1111_1110: return 4'd8;
            8'b1111_0110: return 4'd9;
            default:      return 4'hf;
        endcase
    endfunction

    task automatic read_scan(input string name, output logic [15:0] value);
        logic [n_digits-1:0] seen;
        seg_t                abcdefgh;
        value = '0;
        seen  = '0;
        repeat (scan_len)
        begin
            @(negedge clk);
            abcdefgh = {<<{hgfedcba}};                  // undo the board pin order.
            if (!$onehot(digit))
            begin
                $display("%s: digit enables are not one hot (%b)", name, digit);
                other_errors++;
            end
            else
            begin
                for (int i = 0; i < n_digits; i++)
                begin
                    if (digit[i])
                        value[i*4 +: 4] = seg_to_digit(abcdefgh);
                end
                if (seg_to_digit(abcdefgh) == 4'hf)
                begin
                    $display("%s: segment pattern %b is not a decimal digit", name, abcdefgh);
                    other_errors++;
                end
                seen = seen | digit;
            end
        end
        if (seen != '1)
        begin
            $display("%s: one scan did not visit every digit (%b)", name, seen);
            other_errors++;
        end
    endtask

    // ffff as expected digits means the count is moving and only the leds count.
    task automatic compare_scan(input string name, input logic [15:0] exp_digits,
                                input logic [3:0] exp_led);
        logic [15:0] first;
        logic [15:0] second;
        repeat (3 * scan_len) @(negedge clk);           // let the newest frame settle.
        read_scan(name, first);
        if (led !== exp_led)
        begin
            $display("FAIL %s led: expected %h, got %h", name, exp_led, led);
            value_errors++;
        end
        if (exp_digits != 16'hffff && first !== exp_digits)
        begin
            $display("FAIL %s: expected %h, got %h", name, exp_digits, first);
            value_errors++;
        end
        if (exp_led[1])
        begin
            repeat (2 * step_period) @(negedge clk);
            read_scan(name, second);
            if (second !== first)
            begin
                $display("FAIL %s hold: expected %h, got %h", name, first, second);
                value_errors++;
            end
        end
    endtask

endmodule

`default_nettype wire

// File: bench/tb_board.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board
    import stopwatch_pkg::*;
();

    localparam int clk_mhz         = 1;
    localparam int step_hz         = 50000;
    localparam int debounce_cycles = 4;
    localparam int scan_period     = 2;
    localparam int step_period     = clk_mhz * 1000000 / step_hz;

    logic                clk = 1'b0;
    logic [3:0]          key;
    logic [3:0]          led;
    logic [n_digits-1:0] digit;
    seg_t                hgfedcba;

    string       names[$];
    logic [2:0]  masks[$];
    int          steps[$];
    logic [15:0] exp_digits[$];
    logic [3:0]  exp_leds[$];

    int seed         = 16833;
    int other_errors = 0;
    int cycle        = 0;
    int vec_start;
    int vec_len;
    int limit;
    int total;
    bit loaded       = 1'b0;

    always #20 clk = ~clk;                              // 40 ns period.

    always @(posedge clk)
        cycle <= cycle + 1;

    board_specific_top #(
        .clk_mhz         (clk_mhz),
        .step_hz         (step_hz),
        .w_key           (4),
        .w_led           (4),
        .debounce_cycles (debounce_cycles),
        .scan_period     (scan_period)
    ) uut (
        .clk      (clk),
        .KEY      (key),
        .LED      (led),
        .digit    (digit),
        .hgfedcba (hgfedcba)
    );

    display_checker #(
        .step_period (step_period),
        .scan_period (scan_period)
    ) disp_check (
        .clk      (clk),
        .digit    (digit),
        .hgfedcba (hgfedcba),
        .led      (led)
    );

    task automatic load_tests();
        int    fd;
        string line;
        string name;
        int    m;
        int    n;
        int    d;
        int    l;
        fd = $fopen("bench/board_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open bench/board_tests.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#")
                continue;
            if ($sscanf(line, "%s %h %d %h %h", name, m, n, d, l) == 5)
            begin
                names.push_back(name);
                masks.push_back(m[2:0]);
                steps.push_back(n);
                exp_digits.push_back(d[15:0]);
                exp_leds.push_back(l[3:0]);
            end
        end
        $fclose(fd);
    endtask

    // a glitch of one or two cycles, too short to pass the debouncer.
    task automatic inject_bounce();
        int k;
        int len;
        k   = $unsigned($random(seed)) % 3;
        len = 1 + $unsigned($random(seed)) % (debounce_cycles - 2);
        key[k] = 1'b0;
        repeat (len) @(negedge clk);
        key[k] = 1'b1;
    endtask

    task automatic wait_until(input int target);
        while (cycle < target)
            @(negedge clk);
    endtask

    initial
    begin
        key = 4'b0111;                                  // reset key held down.
        repeat (2) @(posedge clk);
        @(negedge clk);
        key[3] = 1'b1;
        load_tests();
        total = 0;
        foreach (steps[i])
            total += steps[i] + 5;
        limit  = total * step_period * 2 + 500;
        loaded = 1'b1;

        foreach (names[i])
        begin
            vec_start = cycle;
            key[2:0]  = ~masks[i];                      // press, active low.
            repeat (8) @(negedge clk);
            key[2:0]  = 3'b111;
            if (steps[i] > 0)
            begin
                wait_until(vec_start + step_period + $unsigned($random(seed)) % 4);
                inject_bounce();
            end
            wait_until(vec_start + steps[i] * step_period + step_period / 2);
            disp_check.compare_scan(names[i], exp_digits[i], exp_leds[i]);
            vec_len = (steps[i] + (exp_leds[i][1] ? 5 : 3)) * step_period;
            wait_until(vec_start + vec_len);
        end

        $display("errors: %0d value mismatches, %0d other failures",
                 disp_check.value_errors, other_errors + disp_check.other_errors);
        if (disp_check.value_errors + disp_check.other_errors + other_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        wait (loaded);
        repeat (limit) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/bcd_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_counter
    import stopwatch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  sw_ctrl_t    ctrl,
    input  logic        step,
    output time_frame_t frame,
    output logic        frame_valid,
    input  logic        frame_ready
);

    time_frame_t count;
    time_frame_t shown;                     // last frame handed to the display.
    logic        transfer;
    logic        reload;

    function automatic time_frame_t bcd_inc(input time_frame_t value);
        time_frame_t result;
        logic        carry;
        result = value;
        carry  = 1'b1;
        for (int i = 0; i < n_digits; i++)
        begin
            if (carry)
            begin
                if (result.digits[i] == 4'd9)
                    result.digits[i] = 4'd0;        // decimal carry to the next digit.
                else
                begin
                    result.digits[i] = result.digits[i] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
        return result;
    endfunction

    assign transfer = frame_valid && frame_ready;
    assign reload   = !frame_valid || frame_ready || ctrl.hold;  // no pending offer.

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            count <= '0;
        else if (ctrl.clear)
            count <= '0;
        else if (step)
            count <= bcd_inc(count);        // 9999 wraps to 0000.
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_valid <= 1'b0;
            shown       <= '0;
        end
        else
        begin
            if (transfer)
                shown <= frame;
            if (reload)
                frame_valid <= !ctrl.hold && (count != (transfer ? frame : shown));
        end
    end

    always_ff @(posedge clk)
    begin
        if (reload)
            frame <= count;                 // payload frozen while offer waits.
    end

endmodule

`default_nettype wire

// File: logic/board_specific_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_specific_top
    import stopwatch_pkg::*;
#(
    parameter int clk_mhz         = 25,
    parameter int step_hz         = 100,
    parameter int w_key           = 4,
    parameter int w_led           = 4,
    parameter int debounce_cycles = 250000,
    parameter int scan_period     = 25000
)
(
    input  logic                clk,
    input  logic [w_key-1:0]    KEY,
    output logic [w_led-1:0]    LED,
    output logic [n_digits-1:0] digit,
    output seg_t                hgfedcba
);

    localparam int step_period = clk_mhz * 1000000 / step_hz;

    logic        rst_n;
    logic [2:0]  keys;
    cmd_t        cmd;
    sw_ctrl_t    ctrl;
    sw_state_t   state;
    logic        step;
    time_frame_t frame;
    logic        frame_valid;
    logic        frame_ready;
    seg_t        abcdefgh;
    logic [3:0]  led_bits;

    assign rst_n = KEY[w_key-1];                    // last key pulls reset low.
    assign keys  = ~KEY[2:0];                       // keys are active low on the board.

    key_conditioner #(
        .debounce_cycles (debounce_cycles)
    ) i_keys (
        .clk   (clk),
        .rst_n (rst_n),
        .keys  (keys),
        .cmd   (cmd)
    );

    stopwatch_fsm i_fsm (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .ctrl  (ctrl),
        .state (state)
    );

    step_timer #(
        .period (step_period)
    ) i_step_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (ctrl.run),
        .strobe (step)
    );

    bcd_counter i_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .step        (step),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready)
    );

    seg_display #(
        .scan_period (scan_period)
    ) i_display (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .digit       (digit),
        .seg         (abcdefgh)
    );

    // led 0 is counting, led 1 is lap hold.
    assign led_bits = {2'b00, state == running_held, state != stopped};
    assign LED      = w_led'(led_bits);

    assign hgfedcba = {<<{abcdefgh}};               // board wires segments in reverse.

endmodule

`default_nettype wire

// File: logic/key_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module key_conditioner
    import stopwatch_pkg::*;
#(
    parameter int debounce_cycles = 4
)
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] keys,
    output cmd_t       cmd
);

    localparam int w_cnt = $clog2(debounce_cycles + 1);

    logic [2:0]            sync_a;
    logic [2:0]            sync_b;
    logic [2:0]            stable;
    logic [2:0]            press;
    logic [2:0][w_cnt-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_a <= '0;
            sync_b <= '0;
        end
        else
        begin
            sync_a <= keys;                         // two flop synchronizer.
            sync_b <= sync_a;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stable <= '0;
            press  <= '0;
            cnt    <= '0;
        end
        else
        begin
            press <= '0;
            for (int i = 0; i < 3; i++)
            begin
                if (sync_b[i] == stable[i])
                    cnt[i] <= '0;                   // a bounce restarts the wait.
                else if (cnt[i] == w_cnt'(debounce_cycles - 1))
                begin
                    cnt[i]    <= '0;
                    stable[i] <= sync_b[i];
                    press[i]  <= sync_b[i];         // pulse on accepted press only.
                end
                else
                    cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign cmd = '{toggle: press[0], clear: press[1], lap: press[2]};

endmodule

`default_nettype wire

// File: logic/seg_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display
    import stopwatch_pkg::*;
#(
    parameter int scan_period = 25000
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  time_frame_t         frame,
    input  logic                frame_valid,
    output logic                frame_ready,
    output logic [n_digits-1:0] digit,
    output seg_t                seg
);

    localparam int w_idx = n_digits > 1 ? $clog2(n_digits) : 1;

    logic             scan_step;
    logic [w_idx-1:0] idx;
    time_frame_t      shown;
    bcd_digit_t       cur;

    step_timer #(
        .period (scan_period)
    ) i_scan_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (1'b1),
        .strobe (scan_step)
    );

    // frames are taken only between full scans.
    assign frame_ready = scan_step && (idx == w_idx'(n_digits - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            idx   <= '0;
            shown <= '0;
        end
        else
        begin
            if (scan_step)
                idx <= frame_ready ? '0 : idx + 1'b1;
            if (frame_valid && frame_ready)
                shown <= frame;
        end
    end

    assign digit = n_digits'(1) << idx;     // one hot, active high.
    assign cur   = shown.digits[idx];

    always_comb
    begin
        case (cur)
            4'd0:    seg = 8'b1111_1100;
            4'd1:    seg = 8'b0110_0000;
            4'd2:    seg = 8'b1101_1010;
            4'd3:    seg = 8'b1111_0010;
            4'd4:    seg = 8'b0110_0110;
            4'd5:    seg = 8'b1011_0110;
            4'd6:    seg = 8'b1011_1110;
            4'd7:    seg = 8'b1110_0000;
            4'd8:    seg = 8'b1111_1110;
            4'd9:    seg = 8'b1111_0110;
            default: seg = 8'b0000_0000;    // blank on a non bcd code.
        endcase
    end

endmodule

`default_nettype wire

// File: logic/step_timer.sv
`timescale 1ns/1ps
`default_nettype none

module step_timer
#(
    parameter int period = 20
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    output logic strobe
);

    localparam int w_cnt = period > 1 ? $clog2(period) : 1;

    logic [w_cnt-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt    <= w_cnt'(period - 1);
            strobe <= 1'b0;
        end
        else if (!enable)
        begin
            cnt    <= w_cnt'(period - 1);   // held at reload until enabled.
            strobe <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt    <= w_cnt'(period - 1);
            strobe <= 1'b1;
        end
        else
        begin
            cnt    <= cnt - 1'b1;
            strobe <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/stopwatch_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module stopwatch_fsm
    import stopwatch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  cmd_t      cmd,
    output sw_ctrl_t  ctrl,
    output sw_state_t state
);

    sw_state_t state_nx;
    logic      clear_q;

    always_comb
    begin
        state_nx = state;
        case (state)
            stopped:
                if (cmd.toggle)
                    state_nx = running;
            running:
                if (cmd.toggle)
                    state_nx = stopped;
                else if (cmd.lap)
                    state_nx = running_held;
            running_held:
                if (cmd.toggle)
                    state_nx = stopped;     // stopping also drops the lap hold.
                else if (cmd.lap)
                    state_nx = running;
            default:
                state_nx = stopped;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= stopped;
            clear_q <= 1'b0;
        end
        else
        begin
            state   <= state_nx;
            clear_q <= cmd.clear && (state == stopped);  // ignored while counting.
        end
    end

    assign ctrl = '{run: state != stopped, clear: clear_q, hold: state == running_held};

endmodule

`default_nettype wire

// File: logic/stopwatch_pkg.sv
`default_nettype none

package stopwatch_pkg;

    localparam int n_digits = 4;                    // displayed bcd digits.

    typedef logic [3:0] bcd_digit_t;

    typedef struct packed {
        bcd_digit_t [n_digits-1:0] digits;          // digit 0 is the least significant.
    } time_frame_t;

    typedef logic [7:0] seg_t;                      // abcdefgh order with h as the point.

    typedef struct packed {
        logic run;
        logic clear;
        logic hold;
    } sw_ctrl_t;

    typedef enum logic [1:0] {
        stopped      = 2'd0,
        running      = 2'd1,
        running_held = 2'd2
    } sw_state_t;

    typedef struct packed {
        logic toggle;
        logic clear;
        logic lap;
    } cmd_t;

endpackage

`default_nettype wire

// File: sources.f
logic/stopwatch_pkg.sv
logic/step_timer.sv
logic/key_conditioner.sv
logic/stopwatch_fsm.sv
logic/bcd_counter.sv
logic/seg_display.sv
logic/board_specific_top.sv
bench/display_checker.sv
bench/tb_board.sv
